/* include/side_ch_cfg.svh */
// side channel IQ capture widths and limits shared by the whole capture path
`ifndef SIDE_CH_CFG_SVH
`define SIDE_CH_CFG_SVH

`define SIDE_CH_TSF_W 64 // 802.11 TSF timer
`define SIDE_CH_IQ_W 16 // one I or Q component
`define SIDE_CH_DATA_W 64 // one DMA word
`define SIDE_CH_BUF_AW 13 // 8192 buffer words
`define SIDE_CH_LEN_W 14 // length and count fields

// largest UDP payload is 65507 bytes, 8188 words of 8 bytes
`define SIDE_CH_UDP_MAX 8188

`define SIDE_CH_GPIO_W 8 // gain status, top bit is agc lock
`define SIDE_CH_RSSI_W 11 // signed, half dB steps

// register whose write starts an auto transfer
`define SIDE_CH_LEN_REG_ADDR 2

`endif

/* design/side_ch_trig_pkg.sv */
// trigger select codes for the side channel IQ capture
package side_ch_trig_pkg;

	typedef enum logic [3:0] {
		FCS_ANY, // any fcs strobe, or free run
		FCS_OK,
		FCS_BAD,
		LONG_PREAMBLE,
		SHORT_PREAMBLE,
		RSSI_RISE, // rssi crosses rssi_th upward
		RSSI_FALL,
		AGC_UNLOCK,
		AGC_LOCK,
		GAIN_RISE, // gain crosses gain_th upward
		GAIN_FALL,
		TX_BB_RISE,
		TX_BB_FALL,
		TX_RF_RISE,
		TX_RF_FALL,
		NONE // never fires
	} trig_sel_e;

endpackage

/* design/side_ch_word_pkg.sv */
// ring buffer word views and capture FSM states for the side channel
`include "side_ch_cfg.svh"

package side_ch_word_pkg;

	localparam int PAIR_W = 2 * `SIDE_CH_IQ_W;
	localparam int PAD_W = `SIDE_CH_DATA_W - PAIR_W - `SIDE_CH_GPIO_W - `SIDE_CH_RSSI_W - 4;

	typedef struct packed {
		logic [PAIR_W-1:0] iq1; // second sample
		logic [PAIR_W-1:0] iq0; // first sample
	} iq_pair_t;

	// status snapshot taken with the first sample
	typedef struct packed {
		logic [PAD_W-1:0] pad;
		logic demod_ongoing;
		logic tx_rf_ongoing;
		logic fcs_good;
		logic signed [`SIDE_CH_RSSI_W-1:0] rssi;
		logic ch_idle;
		logic [`SIDE_CH_GPIO_W-1:0] gain;
		logic [PAIR_W-1:0] iq0;
	} status_t;

	typedef union packed {
		iq_pair_t iq_pair;
		status_t status;
	} iq_word_u;

	typedef enum logic [1:0] {WAIT_TRIGGER, CHECK_ROOM, SEND_HEADER, SEND_SAMPLES} capture_state_e;

endpackage

/* design/iq_trigger_detect.sv */
// event edge detection and trigger select, one registered trigger pulse out
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module iq_trigger_detect (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input side_ch_trig_pkg::trig_sel_e iq_trigger_select,
	input logic iq_trigger_free_run_flag,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_half_db,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_th,
	input logic [`SIDE_CH_GPIO_W-1:0] gpio_status,
	input logic [`SIDE_CH_GPIO_W-2:0] gain_th,
	input logic tx_bb_is_ongoing,
	input logic tx_rf_is_ongoing,
	output logic trig_pulse
);
	import side_ch_trig_pkg::*;

	localparam int GPIO_W = `SIDE_CH_GPIO_W;
	// bit positions in the level vectors
	localparam int L_RSSI = 0;
	localparam int L_GAIN = 1;
	localparam int L_AGC = 2;
	localparam int L_TXBB = 3;
	localparam int L_TXRF = 4;

	logic signed [`SIDE_CH_RSSI_W-1:0] rssi_d;
	logic [GPIO_W-1:0] gpio_d;
	logic tx_bb_d;
	logic tx_rf_d;
	logic [4:0] lvl_now;
	logic [4:0] lvl_prev;
	logic [4:0] rise;
	logic [4:0] fall;

	// threshold crossings become levels, so every edge is found the same way
	assign lvl_now = {tx_rf_is_ongoing, tx_bb_is_ongoing, gpio_status[GPIO_W-1],
		gpio_status[GPIO_W-2:0] >= gain_th, rssi_half_db >= rssi_th};
	assign lvl_prev = {tx_rf_d, tx_bb_d, gpio_d[GPIO_W-1], gpio_d[GPIO_W-2:0] >= gain_th,
		rssi_d >= rssi_th};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_d <= '0;
			gpio_d <= '0;
			tx_bb_d <= 1'b0;
			tx_rf_d <= 1'b0;
			rise <= '0;
			fall <= '0;
		end else begin
			rssi_d <= rssi_half_db;
			gpio_d <= gpio_status;
			tx_bb_d <= tx_bb_is_ongoing;
			tx_rf_d <= tx_rf_is_ongoing;
			rise <= iq_capture ? (lvl_now & ~lvl_prev) : '0;
			fall <= iq_capture ? (~lvl_now & lvl_prev) : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn || !iq_capture) begin
			trig_pulse <= 1'b0;
		end else begin
			case (iq_trigger_select)
				FCS_ANY: trig_pulse <= fcs_in_strobe | iq_trigger_free_run_flag;
				FCS_OK: trig_pulse <= fcs_in_strobe & fcs_ok;
				FCS_BAD: trig_pulse <= fcs_in_strobe & ~fcs_ok;
				LONG_PREAMBLE: trig_pulse <= long_preamble_detected;
				SHORT_PREAMBLE: trig_pulse <= short_preamble_detected;
				RSSI_RISE: trig_pulse <= rise[L_RSSI];
				RSSI_FALL: trig_pulse <= fall[L_RSSI];
				AGC_UNLOCK: trig_pulse <= fall[L_AGC]; // lock bit drops
				AGC_LOCK: trig_pulse <= rise[L_AGC];
				GAIN_RISE: trig_pulse <= rise[L_GAIN];
				GAIN_FALL: trig_pulse <= fall[L_GAIN];
				TX_BB_RISE: trig_pulse <= rise[L_TXBB];
				TX_BB_FALL: trig_pulse <= fall[L_TXBB];
				TX_RF_RISE: trig_pulse <= rise[L_TXRF];
				TX_RF_FALL: trig_pulse <= fall[L_TXRF];
				default: trig_pulse <= 1'b0;
			endcase
		end
	end

	a_trig_needs_capture: assert property (@(posedge clk) disable iff (!rstn)
		trig_pulse |-> $past(iq_capture));

endmodule

/* design/iq_ring_buffer.sv */
// ring buffer of IQ pairs or status snapshots, one word per IQ strobe
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module iq_ring_buffer (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input logic [1:0] iq_capture_cfg,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq0,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq1,
	input logic iq_strobe,
	input logic [`SIDE_CH_GPIO_W-1:0] gpio_status,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_half_db,
	input logic demod_is_ongoing,
	input logic tx_rf_is_ongoing,
	input logic ch_idle_final,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic [`SIDE_CH_BUF_AW-1:0] rd_addr,
	output logic [`SIDE_CH_BUF_AW-1:0] wr_addr,
	output side_ch_word_pkg::iq_word_u rd_word
);
	import side_ch_word_pkg::*;

	localparam int DEPTH = 2 ** `SIDE_CH_BUF_AW;

	iq_word_u mem [0:DEPTH-1];
	iq_word_u wr_word;
	logic fcs_good;
	logic wr_en;

	assign wr_en = iq_capture & iq_strobe;

	// good fcs seen, held until the next packet starts
	always_ff @(posedge clk) begin
		if (!rstn) begin
			fcs_good <= 1'b0;
		end else if (fcs_in_strobe && fcs_ok) begin
			fcs_good <= 1'b1;
		end else if (long_preamble_detected) begin
			fcs_good <= 1'b0;
		end
	end

	always_comb begin
		wr_word = '0;
		if (iq_capture_cfg[0]) begin // two samples per word
			wr_word.iq_pair.iq1 = iq1;
			wr_word.iq_pair.iq0 = iq0;
		end else begin
			wr_word.status.demod_ongoing = demod_is_ongoing;
			wr_word.status.tx_rf_ongoing = tx_rf_is_ongoing;
			wr_word.status.fcs_good = fcs_good;
			wr_word.status.rssi = rssi_half_db;
			wr_word.status.ch_idle = ch_idle_final;
			wr_word.status.gain = gpio_status;
			wr_word.status.iq0 = iq0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_addr <= '0;
		end else if (wr_en) begin
			wr_addr <= wr_addr + 1'b1; // wraps around the ring
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_word;
		end
		rd_word <= mem[rd_addr];
	end

endmodule

/* design/iq_read_counter.sv */
// read pointer and sample count for one capture
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module iq_read_counter (
	input logic clk,
	input logic rstn,
	input side_ch_word_pkg::capture_state_e state,
	input logic trig_pulse,
	input logic [`SIDE_CH_BUF_AW-1:0] wr_addr,
	input logic [`SIDE_CH_LEN_W-1:0] pre_trigger_len,
	input logic iq_strobe,
	output logic [`SIDE_CH_BUF_AW-1:0] rd_addr,
	output logic [`SIDE_CH_LEN_W-1:0] sample_count
);
	import side_ch_word_pkg::*;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_addr <= '0;
			sample_count <= '0;
		end else if (state == WAIT_TRIGGER) begin
			sample_count <= '0;
			if (trig_pulse) begin
				// go back pre_trigger_len writes, modulo the ring
				rd_addr <= wr_addr - pre_trigger_len[`SIDE_CH_BUF_AW-1:0];
			end
		end else if (state == SEND_SAMPLES && iq_strobe) begin
			rd_addr <= rd_addr + 1'b1;
			sample_count <= sample_count + 1'b1;
		end
	end

	// the FSM stops at iq_len_target, so the count must not wrap
	a_count_no_wrap: assert property (@(posedge clk) disable iff (!rstn)
		(state == SEND_SAMPLES && iq_strobe) |-> sample_count != '1);

endmodule

/* design/iq_capture_fsm.sv */
// capture FSM with TSF lock at the trigger and DMA FIFO room check
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module iq_capture_fsm (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input logic trig_pulse,
	input logic [`SIDE_CH_TSF_W-1:0] tsf_runtime_val,
	input logic [`SIDE_CH_LEN_W-1:0] m_axis_data_count,
	input logic [`SIDE_CH_LEN_W-1:0] iq_len_target,
	input logic [`SIDE_CH_LEN_W-1:0] sample_count,
	input logic iq_strobe,
	output side_ch_word_pkg::capture_state_e state,
	output logic [`SIDE_CH_TSF_W-1:0] tsf_lock,
	output logic header_valid,
	output logic sample_valid,
	output logic sample_busy
);
	import side_ch_word_pkg::*;

	localparam int LEN_W = `SIDE_CH_LEN_W;
	localparam logic [LEN_W:0] UDP_MAX = `SIDE_CH_UDP_MAX;

	logic [LEN_W:0] room;
	logic [LEN_W:0] need;
	logic room_ok;
	logic [LEN_W-1:0] count_next;
	logic done;
	logic last_sample;

	// header plus samples must fit in what is left of the DMA FIFO
	assign room = UDP_MAX - {1'b0, m_axis_data_count};
	assign need = {1'b0, iq_len_target} + 1'b1;
	assign room_ok = (m_axis_data_count <= UDP_MAX) && (room >= need);

	assign count_next = sample_count + 1'b1;
	assign done = (sample_count == iq_len_target); // covers a zero target
	assign header_valid = (state == SEND_HEADER);
	assign sample_valid = (state == SEND_SAMPLES) && iq_strobe && !done;
	assign last_sample = sample_valid && (count_next == iq_len_target);
	assign sample_busy = (state == SEND_HEADER) || (state == SEND_SAMPLES);

	always_ff @(posedge clk) begin
		if (!rstn || !iq_capture) begin
			state <= WAIT_TRIGGER;
		end else begin
			case (state)
				WAIT_TRIGGER: if (trig_pulse) state <= CHECK_ROOM;
				CHECK_ROOM: state <= room_ok ? SEND_HEADER : WAIT_TRIGGER; // refused, no output
				SEND_HEADER: state <= SEND_SAMPLES;
				SEND_SAMPLES: if (done || last_sample) state <= WAIT_TRIGGER;
				default: state <= WAIT_TRIGGER;
			endcase
		end
	end

	// timestamp of the trigger cycle, sent as the header word
	always_ff @(posedge clk) begin
		if (state == WAIT_TRIGGER && trig_pulse) begin
			tsf_lock <= tsf_runtime_val;
		end
	end

	a_one_word_kind: assert property (@(posedge clk) disable iff (!rstn)
		!(header_valid && sample_valid));

endmodule

/* design/iq_stream_out.sv */
// DMA word select, mode gating and start-of-transfer strobe
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module iq_stream_out (
	input logic clk,
	input logic rstn,
	input logic [1:0] m_axis_start_mode,
	input logic m_axis_start_ext_trigger,
	input logic slv_reg_wren_signal,
	input logic [4:0] axi_awaddr_core,
	input logic [`SIDE_CH_TSF_W-1:0] tsf_lock,
	input logic header_valid,
	input side_ch_word_pkg::iq_word_u rd_word,
	input logic sample_valid,
	output logic [`SIDE_CH_DATA_W-1:0] data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans
);
	localparam logic [1:0] MODE_AUTO = 2'd1;
	localparam logic [1:0] MODE_EXT = 2'd2;
	localparam logic [4:0] LEN_REG_ADDR = `SIDE_CH_LEN_REG_ADDR;

	logic reg_wr_hit;
	logic reg_wr_d1;
	logic reg_wr_d2;
	logic auto_start;
	logic mode_on;

	assign reg_wr_hit = slv_reg_wren_signal && (axi_awaddr_core == LEN_REG_ADDR);
	assign auto_start = reg_wr_d1 & ~reg_wr_d2; // first cycle of the write only
	assign mode_on = (m_axis_start_mode == MODE_AUTO) || (m_axis_start_mode == MODE_EXT);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			reg_wr_d1 <= 1'b0;
			reg_wr_d2 <= 1'b0;
			m_axis_start_1trans <= 1'b0;
			data_to_ps_valid <= 1'b0;
		end else begin
			reg_wr_d1 <= reg_wr_hit;
			reg_wr_d2 <= reg_wr_d1;
			case (m_axis_start_mode)
				MODE_AUTO: m_axis_start_1trans <= auto_start;
				MODE_EXT: m_axis_start_1trans <= m_axis_start_ext_trigger;
				default: m_axis_start_1trans <= 1'b0; // modes 0 and 3 are off
			endcase
			data_to_ps_valid <= mode_on && (header_valid || sample_valid);
		end
	end

	always_ff @(posedge clk) begin
		if (!mode_on) begin
			data_to_ps <= '0;
		end else begin
			data_to_ps <= header_valid ? tsf_lock : rd_word;
		end
	end

endmodule

/* design/side_ch_iq_capture.sv */
// side channel IQ capture top, trigger, ring buffer, FSM and DMA stream
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module side_ch_iq_capture (
	input logic clk,
	input logic rstn,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq0,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq1,
	input logic iq_strobe,
	input logic [`SIDE_CH_GPIO_W-1:0] gpio_status,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_half_db,
	input logic [`SIDE_CH_TSF_W-1:0] tsf_runtime_val,
	input logic demod_is_ongoing,
	input logic ch_idle_final,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic tx_bb_is_ongoing,
	input logic tx_rf_is_ongoing,
	input logic iq_capture,
	input logic [1:0] iq_capture_cfg,
	input side_ch_trig_pkg::trig_sel_e iq_trigger_select,
	input logic iq_trigger_free_run_flag,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_th,
	input logic [`SIDE_CH_GPIO_W-2:0] gain_th,
	input logic [`SIDE_CH_LEN_W-1:0] pre_trigger_len,
	input logic [`SIDE_CH_LEN_W-1:0] iq_len_target,
	input logic [`SIDE_CH_LEN_W-1:0] m_axis_data_count,
	input logic slv_reg_wren_signal,
	input logic [4:0] axi_awaddr_core,
	input logic [1:0] m_axis_start_mode,
	input logic m_axis_start_ext_trigger,
	output logic [`SIDE_CH_DATA_W-1:0] data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans
);
	import side_ch_word_pkg::*;

	logic trig_pulse;
	logic [`SIDE_CH_BUF_AW-1:0] wr_addr;
	logic [`SIDE_CH_BUF_AW-1:0] rd_addr;
	iq_word_u rd_word;
	logic [`SIDE_CH_LEN_W-1:0] sample_count;
	capture_state_e state;
	logic [`SIDE_CH_TSF_W-1:0] tsf_lock;
	logic header_valid;
	logic sample_valid;
	logic sample_busy; // end of capture, watched from the testbench

	iq_trigger_detect u_trig (.clk(clk), .rstn(rstn), .iq_capture(iq_capture),
		.iq_trigger_select(iq_trigger_select), .iq_trigger_free_run_flag(iq_trigger_free_run_flag),
		.fcs_in_strobe(fcs_in_strobe), .fcs_ok(fcs_ok),
		.long_preamble_detected(long_preamble_detected),
		.short_preamble_detected(short_preamble_detected), .rssi_half_db(rssi_half_db),
		.rssi_th(rssi_th), .gpio_status(gpio_status), .gain_th(gain_th),
		.tx_bb_is_ongoing(tx_bb_is_ongoing), .tx_rf_is_ongoing(tx_rf_is_ongoing),
		.trig_pulse(trig_pulse));

	iq_ring_buffer u_buf (.clk(clk), .rstn(rstn), .iq_capture(iq_capture),
		.iq_capture_cfg(iq_capture_cfg), .iq0(iq0), .iq1(iq1), .iq_strobe(iq_strobe),
		.gpio_status(gpio_status), .rssi_half_db(rssi_half_db),
		.demod_is_ongoing(demod_is_ongoing), .tx_rf_is_ongoing(tx_rf_is_ongoing),
		.ch_idle_final(ch_idle_final), .fcs_in_strobe(fcs_in_strobe), .fcs_ok(fcs_ok),
		.long_preamble_detected(long_preamble_detected), .rd_addr(rd_addr),
		.wr_addr(wr_addr), .rd_word(rd_word));

	iq_read_counter u_rd (.clk(clk), .rstn(rstn), .state(state), .trig_pulse(trig_pulse),
		.wr_addr(wr_addr), .pre_trigger_len(pre_trigger_len), .iq_strobe(iq_strobe),
		.rd_addr(rd_addr), .sample_count(sample_count));

	iq_capture_fsm u_fsm (.clk(clk), .rstn(rstn), .iq_capture(iq_capture),
		.trig_pulse(trig_pulse), .tsf_runtime_val(tsf_runtime_val),
		.m_axis_data_count(m_axis_data_count), .iq_len_target(iq_len_target),
		.sample_count(sample_count), .iq_strobe(iq_strobe), .state(state),
		.tsf_lock(tsf_lock), .header_valid(header_valid), .sample_valid(sample_valid),
		.sample_busy(sample_busy));

	iq_stream_out u_out (.clk(clk), .rstn(rstn), .m_axis_start_mode(m_axis_start_mode),
		.m_axis_start_ext_trigger(m_axis_start_ext_trigger),
		.slv_reg_wren_signal(slv_reg_wren_signal), .axi_awaddr_core(axi_awaddr_core),
		.tsf_lock(tsf_lock), .header_valid(header_valid), .rd_word(rd_word),
		.sample_valid(sample_valid), .data_to_ps(data_to_ps),
		.data_to_ps_valid(data_to_ps_valid), .m_axis_start_1trans(m_axis_start_1trans));

endmodule

/* testbench/side_ch_iq_checker.sv */
// DMA output checker that mirrors the ring buffer and compares each streamed word
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module side_ch_iq_checker (
	input logic clk,
	input logic rstn,
	input logic iq_strobe,
	input logic iq_capture,
	input logic [1:0] iq_capture_cfg,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq0,
	input logic [2*`SIDE_CH_IQ_W-1:0] iq1,
	input logic [`SIDE_CH_GPIO_W-1:0] gpio_status,
	input logic signed [`SIDE_CH_RSSI_W-1:0] rssi_half_db,
	input logic demod_is_ongoing,
	input logic tx_rf_is_ongoing,
	input logic ch_idle_final,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic [`SIDE_CH_TSF_W-1:0] tsf_runtime_val,
	input logic slv_reg_wren_signal,
	input logic [4:0] axi_awaddr_core,
	input logic [1:0] m_axis_start_mode,
	input logic m_axis_start_ext_trigger,
	input logic arm,
	input logic close_row,
	input logic exp_capture,
	input logic [`SIDE_CH_TSF_W-1:0] exp_tsf,
	input logic [`SIDE_CH_LEN_W-1:0] exp_len,
	input logic [`SIDE_CH_LEN_W-1:0] exp_pre,
	input logic [`SIDE_CH_DATA_W-1:0] data_to_ps,
	input logic data_to_ps_valid,
	input logic m_axis_start_1trans,
	output int errors,
	output int checks
);
	import side_ch_word_pkg::*;

	localparam int DEPTH = 2 ** `SIDE_CH_BUF_AW;

	iq_word_u mirror [0:DEPTH-1];
	iq_word_u w;
	logic [`SIDE_CH_BUF_AW-1:0] wcnt;
	logic [`SIDE_CH_BUF_AW-1:0] base;
	logic [`SIDE_CH_BUF_AW-1:0] idx;
	logic fcs_good_m;
	logic live;
	logic hit_d1;
	logic exp_start;
	logic quiet_mode;
	logic cap_on;
	logic cap_exp;
	logic [`SIDE_CH_TSF_W-1:0] cap_tsf;
	logic [`SIDE_CH_LEN_W-1:0] cap_len;
	logic [`SIDE_CH_LEN_W-1:0] cap_pre;
	int got;

	task automatic compare_value(input string name, input logic [63:0] act,
		input logic [63:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		live = 1'b0;
	end

	// inputs sampled at the rising edge as the DUT sees them
	always @(posedge clk) begin
		live = rstn;
		if (!rstn) begin
			wcnt = '0;
			fcs_good_m = 1'b0;
			hit_d1 = 1'b0;
			exp_start = 1'b0;
			quiet_mode = 1'b0;
			cap_on = 1'b0;
			got = 0;
		end else begin
			case (m_axis_start_mode)
				2'd1: exp_start = hit_d1; // two cycles after the write
				2'd2: exp_start = m_axis_start_ext_trigger;
				default: exp_start = 1'b0;
			endcase
			hit_d1 = slv_reg_wren_signal && (axi_awaddr_core == `SIDE_CH_LEN_REG_ADDR);
			quiet_mode = (m_axis_start_mode == 2'd0) || (m_axis_start_mode == 2'd3);
			if (arm) begin
				cap_on = 1'b1;
				cap_exp = exp_capture;
				cap_tsf = exp_tsf;
				cap_len = exp_len;
				cap_pre = exp_pre;
				got = 0;
			end
			// trigger edge is where the TSF reaches the expected header
			if (cap_on && tsf_runtime_val == cap_tsf) begin
				base = wcnt - cap_pre[`SIDE_CH_BUF_AW-1:0];
			end
			if (iq_capture && iq_strobe) begin
				w = '0;
				if (iq_capture_cfg[0]) begin
					w.iq_pair.iq1 = iq1;
					w.iq_pair.iq0 = iq0;
				end else begin
					w.status.demod_ongoing = demod_is_ongoing;
					w.status.tx_rf_ongoing = tx_rf_is_ongoing;
					w.status.fcs_good = fcs_good_m;
					w.status.rssi = rssi_half_db;
					w.status.ch_idle = ch_idle_final;
					w.status.gain = gpio_status;
					w.status.iq0 = iq0;
				end
				mirror[wcnt] = w;
				wcnt = wcnt + 1'b1;
			end
			if (fcs_in_strobe && fcs_ok) begin
				fcs_good_m = 1'b1;
			end else if (long_preamble_detected) begin
				fcs_good_m = 1'b0;
			end
			if (close_row && cap_on) begin
				if (cap_exp && got != cap_len + 1) begin
					errors++;
					$display("capture incomplete, %0d of %0d words arrived before %0t",
						got, cap_len + 1, $time);
				end
				cap_on = 1'b0;
			end
		end
	end

	// outputs are compared half a cycle after they change
	always @(negedge clk) begin
		if (live) begin
			compare_value("m_axis_start_1trans", m_axis_start_1trans, exp_start);
			if (quiet_mode && (data_to_ps_valid !== 1'b0 || data_to_ps !== '0)) begin
				errors++;
				$display("output is active although the start mode is off, at %0t", $time);
			end
			if (data_to_ps_valid === 1'b1) begin
				if (!cap_on || !cap_exp || got > cap_len) begin
					errors++;
					$display("unexpected output word %h at %0t", data_to_ps, $time);
				end else if (got == 0) begin
					compare_value("data_to_ps", data_to_ps, cap_tsf); // header
					got++;
				end else begin
					idx = base + got[`SIDE_CH_BUF_AW-1:0] - 1'b1;
					compare_value("data_to_ps", data_to_ps, mirror[idx]);
					got++;
				end
			end
		end
	end

endmodule

/* testbench/tb_side_ch_iq_capture.sv */
// table driven testbench for the side channel IQ capture path
`timescale 1ns/1ps
`include "side_ch_cfg.svh"

module tb_side_ch_iq_capture;
	import side_ch_trig_pkg::*;

	typedef struct packed {
		trig_sel_e sel;
		trig_sel_e ev; // event driven on the inputs
		logic [1:0] cfg;
		logic [`SIDE_CH_LEN_W-1:0] pre;
		logic [`SIDE_CH_LEN_W-1:0] len;
		logic [`SIDE_CH_LEN_W-1:0] fifo_cnt;
		logic [1:0] mode;
		logic cap; // capture expected
	} row_t;

	logic clk;
	logic rstn;
	logic [2*`SIDE_CH_IQ_W-1:0] iq0;
	logic [2*`SIDE_CH_IQ_W-1:0] iq1;
	logic iq_strobe;
	logic [`SIDE_CH_GPIO_W-1:0] gpio_status;
	logic signed [`SIDE_CH_RSSI_W-1:0] rssi_half_db;
	logic [`SIDE_CH_TSF_W-1:0] tsf_runtime_val;
	logic demod_is_ongoing;
	logic ch_idle_final;
	logic fcs_in_strobe;
	logic fcs_ok;
	logic long_preamble_detected;
	logic short_preamble_detected;
	logic tx_bb_is_ongoing;
	logic tx_rf_is_ongoing;
	logic iq_capture;
	logic [1:0] iq_capture_cfg;
	trig_sel_e iq_trigger_select;
	logic iq_trigger_free_run_flag;
	logic signed [`SIDE_CH_RSSI_W-1:0] rssi_th;
	logic [`SIDE_CH_GPIO_W-2:0] gain_th;
	logic [`SIDE_CH_LEN_W-1:0] pre_trigger_len;
	logic [`SIDE_CH_LEN_W-1:0] iq_len_target;
	logic [`SIDE_CH_LEN_W-1:0] m_axis_data_count;
	logic slv_reg_wren_signal;
	logic [4:0] axi_awaddr_core;
	logic [1:0] m_axis_start_mode;
	logic m_axis_start_ext_trigger;
	logic [`SIDE_CH_DATA_W-1:0] data_to_ps;
	logic data_to_ps_valid;
	logic m_axis_start_1trans;

	// expectation handed to the checker
	logic arm;
	logic close_row;
	logic exp_capture;
	logic [`SIDE_CH_TSF_W-1:0] exp_tsf;
	logic [`SIDE_CH_LEN_W-1:0] exp_len;
	logic [`SIDE_CH_LEN_W-1:0] exp_pre;
	int errors;
	int checks;

	row_t rows [$];
	logic [15:0] lfsr = 16'd38;
	logic [31:0] bits;
	int strobe_div = 0;
	int total_len = 0;
	int limit = 0;

	side_ch_iq_capture u_dut (.*);
	side_ch_iq_checker u_chk (.*);

	always #2 clk = ~clk;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_step(lfsr); // one step per bit
		end
	endtask

	// free running TSF and an IQ strobe every fifth cycle
	always @(negedge clk) begin
		tsf_runtime_val <= tsf_runtime_val + 1'b1;
		iq_strobe = (strobe_div == 4);
		strobe_div = (strobe_div == 4) ? 0 : strobe_div + 1;
		if (iq_strobe) begin
			take_bits(32, bits);
			iq0 = bits;
			take_bits(32, bits);
			iq1 = bits;
			take_bits(2, bits);
			demod_is_ongoing = bits[0];
			ch_idle_final = bits[1];
		end
	end

	task automatic add_row(input trig_sel_e sel, input trig_sel_e ev, input logic [1:0] cfg,
		input int pre, input int len, input int cnt, input logic [1:0] mode, input logic cap);
		row_t r;
		r.sel = sel;
		r.ev = ev;
		r.cfg = cfg;
		r.pre = pre;
		r.len = len;
		r.fifo_cnt = cnt;
		r.mode = mode;
		r.cap = cap;
		rows.push_back(r);
		total_len += len;
	endtask

	task automatic drive_event(input trig_sel_e ev);
		case (ev)
			FCS_ANY: iq_trigger_free_run_flag = 1'b1;
			FCS_OK: begin
				fcs_in_strobe = 1'b1;
				fcs_ok = 1'b1;
			end
			FCS_BAD: begin
				fcs_in_strobe = 1'b1;
				fcs_ok = 1'b0;
			end
			LONG_PREAMBLE: long_preamble_detected = 1'b1;
			SHORT_PREAMBLE: short_preamble_detected = 1'b1;
			RSSI_RISE: rssi_half_db = -11'sd40;
			RSSI_FALL: rssi_half_db = -11'sd100;
			AGC_LOCK: gpio_status[7] = 1'b1;
			AGC_UNLOCK: gpio_status[7] = 1'b0;
			GAIN_RISE: gpio_status[6:0] = 7'd60;
			GAIN_FALL: gpio_status[6:0] = 7'd10;
			TX_BB_RISE: tx_bb_is_ongoing = 1'b1;
			TX_BB_FALL: tx_bb_is_ongoing = 1'b0;
			TX_RF_RISE: tx_rf_is_ongoing = 1'b1;
			TX_RF_FALL: tx_rf_is_ongoing = 1'b0;
			default: ;
		endcase
	endtask

	task automatic run_row(input row_t r);
		logic edge_ev;
		edge_ev = (r.ev >= RSSI_RISE) && (r.ev != NONE);
		@(negedge clk);
		iq_trigger_select = r.sel;
		iq_capture_cfg = r.cfg;
		pre_trigger_len = r.pre;
		iq_len_target = r.len;
		m_axis_data_count = r.fifo_cnt;
		m_axis_start_mode = r.mode;
		slv_reg_wren_signal = 1'b1; // length register write
		axi_awaddr_core = 5'd2;
		@(negedge clk);
		slv_reg_wren_signal = 1'b0;
		m_axis_start_ext_trigger = 1'b1;
		@(negedge clk);
		m_axis_start_ext_trigger = 1'b0;
		slv_reg_wren_signal = 1'b1;
		axi_awaddr_core = 5'd3; // other register, no start
		@(negedge clk);
		slv_reg_wren_signal = 1'b0;
		repeat (3) @(negedge clk);
		// TSF still holds the old value here, its update lands before the next edge
		exp_tsf = tsf_runtime_val + (edge_ev ? 64'd3 : 64'd2);
		exp_len = r.len;
		exp_pre = r.pre;
		exp_capture = r.cap;
		arm = 1'b1;
		drive_event(r.ev);
		@(negedge clk);
		arm = 1'b0;
		iq_trigger_free_run_flag = 1'b0;
		fcs_in_strobe = 1'b0;
		long_preamble_detected = 1'b0;
		short_preamble_detected = 1'b0;
		repeat (8) @(negedge clk);
		while (u_dut.sample_busy) @(negedge clk);
		repeat (2) @(negedge clk);
		close_row = 1'b1;
		@(negedge clk);
		close_row = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		iq0 = '0;
		iq1 = '0;
		iq_strobe = 1'b0;
		gpio_status = 8'h0a; // gain 10, agc unlocked
		rssi_half_db = -11'sd100;
		tsf_runtime_val = 64'h0000_0100_0000_0000;
		demod_is_ongoing = 1'b0;
		ch_idle_final = 1'b0;
		fcs_in_strobe = 1'b0;
		fcs_ok = 1'b0;
		long_preamble_detected = 1'b0;
		short_preamble_detected = 1'b0;
		tx_bb_is_ongoing = 1'b0;
		tx_rf_is_ongoing = 1'b0;
		iq_capture = 1'b0;
		iq_capture_cfg = 2'd0;
		iq_trigger_select = NONE;
		iq_trigger_free_run_flag = 1'b0;
		rssi_th = -11'sd60;
		gain_th = 7'd40;
		pre_trigger_len = '0;
		iq_len_target = '0;
		m_axis_data_count = '0;
		slv_reg_wren_signal = 1'b0;
		axi_awaddr_core = '0;
		m_axis_start_mode = 2'd0;
		m_axis_start_ext_trigger = 1'b0;
		arm = 1'b0;
		close_row = 1'b0;
		exp_capture = 1'b0;
		exp_tsf = '0;
		exp_len = '0;
		exp_pre = '0;

		// sel, event, cfg, pre, len, fifo count, mode, capture expected
		add_row(FCS_OK, NONE, 2'd1, 2, 3, 0, 2'd1, 1'b0);
		add_row(FCS_ANY, FCS_ANY, 2'd1, 3, 4, 0, 2'd1, 1'b1);
		add_row(FCS_OK, FCS_OK, 2'd0, 2, 5, 100, 2'd2, 1'b1);
		add_row(FCS_OK, FCS_BAD, 2'd0, 2, 3, 0, 2'd1, 1'b0);
		add_row(FCS_BAD, FCS_BAD, 2'd1, 4, 3, 0, 2'd2, 1'b1);
		add_row(LONG_PREAMBLE, LONG_PREAMBLE, 2'd0, 1, 6, 0, 2'd1, 1'b1);
		add_row(SHORT_PREAMBLE, SHORT_PREAMBLE, 2'd1, 5, 2, 0, 2'd1, 1'b1);
		add_row(RSSI_RISE, RSSI_RISE, 2'd0, 3, 4, 0, 2'd2, 1'b1);
		add_row(RSSI_FALL, RSSI_FALL, 2'd1, 2, 3, 0, 2'd1, 1'b1);
		add_row(AGC_LOCK, AGC_LOCK, 2'd0, 6, 5, 0, 2'd1, 1'b1);
		add_row(AGC_UNLOCK, AGC_UNLOCK, 2'd1, 1, 2, 0, 2'd2, 1'b1);
		add_row(GAIN_RISE, GAIN_RISE, 2'd0, 4, 3, 0, 2'd1, 1'b1);
		add_row(GAIN_FALL, GAIN_FALL, 2'd1, 2, 4, 0, 2'd1, 1'b1);
		add_row(TX_BB_RISE, TX_BB_RISE, 2'd0, 3, 3, 0, 2'd2, 1'b1);
		add_row(TX_BB_FALL, TX_BB_FALL, 2'd1, 5, 2, 0, 2'd1, 1'b1);
		add_row(TX_RF_RISE, TX_RF_RISE, 2'd0, 2, 5, 0, 2'd1, 1'b1);
		add_row(TX_RF_FALL, TX_RF_FALL, 2'd1, 1, 3, 0, 2'd2, 1'b1);
		add_row(FCS_OK, FCS_OK, 2'd1, 2, 8, 8180, 2'd1, 1'b0); // no room
		add_row(FCS_OK, FCS_OK, 2'd1, 2, 8, 8179, 2'd1, 1'b1); // exact fit
		add_row(FCS_OK, FCS_OK, 2'd0, 2, 3, 0, 2'd0, 1'b0);
		add_row(FCS_OK, FCS_OK, 2'd1, 2, 3, 0, 2'd3, 1'b0);
		add_row(NONE, FCS_OK, 2'd1, 2, 3, 0, 2'd1, 1'b0);
		limit = 16 + 40 + total_len * 10 + rows.size() * 60 + 200;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		iq_capture = 1'b1;
		repeat (40) @(negedge clk); // fill the ring ahead of the first pre-trigger window
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		repeat (5) @(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		wait (limit > 0);
		repeat (limit) @(posedge clk);
		$display("timeout, the run did not end within %0d cycles", limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* side_ch_iq_capture.f */
+incdir+include
design/side_ch_trig_pkg.sv
design/side_ch_word_pkg.sv
design/iq_trigger_detect.sv
design/iq_ring_buffer.sv
design/iq_read_counter.sv
design/iq_capture_fsm.sv
design/iq_stream_out.sv
design/side_ch_iq_capture.sv
testbench/side_ch_iq_checker.sv
testbench/tb_side_ch_iq_capture.sv

/* Bender.yml */
package:
  name: side_ch_iq_capture

sources:
  - include_dirs:
      - include
    files:
      - design/side_ch_trig_pkg.sv
      - design/side_ch_word_pkg.sv
      - design/iq_trigger_detect.sv
      - design/iq_ring_buffer.sv
      - design/iq_read_counter.sv
      - design/iq_capture_fsm.sv
      - design/iq_stream_out.sv
      - design/side_ch_iq_capture.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/side_ch_iq_checker.sv
      - testbench/tb_side_ch_iq_capture.sv
